// File: csr_access_unit.sv
module csr_access_unit (
  input  logic                            csr_req_i,
  input  logic [csr_pkg::csr_addr_w-1:0]  csr_addr_i,
  input  csr_pkg::csr_op_t                csr_op_i,
  input  logic [csr_pkg::xlen-1:0]        csr_src_i,
  input  logic [csr_pkg::xlen-1:0]        rd_data_i,
  output logic [csr_pkg::csr_addr_w-1:0]  rd_addr_o,
  output logic [csr_pkg::xlen-1:0]        csr_rdata_o,
  output logic                            csr_illegal_o,
  output logic                            wr_en_o,
  output logic [csr_pkg::csr_addr_w-1:0]  wr_addr_o,
  output logic [csr_pkg::xlen-1:0]        wr_data_o
);

  logic                     addr_ok;
  logic [csr_pkg::xlen-1:0] new_val;

  // ####################
  // address decode
  // ####################

  always_comb begin
    case (csr_addr_i)
      csr_pkg::csr_mstatus,
      csr_pkg::csr_mtvec,
      csr_pkg::csr_mepc,
      csr_pkg::csr_mcause,
      csr_pkg::csr_mtval: addr_ok = 1'b1;
      default:            addr_ok = 1'b0;
    endcase
  end

  // the read is issued in the request cycle, the old value comes back the same cycle.
  assign rd_addr_o = csr_addr_i;

  assign csr_illegal_o = csr_req_i & ~addr_ok;
  assign csr_rdata_o   = (csr_req_i && addr_ok) ? rd_data_i : '0;

  // ####################
  // read-modify-write
  // ####################

  always_comb begin
    case (csr_op_i)
      csr_pkg::op_rw: new_val = csr_src_i;
      csr_pkg::op_rs: new_val = rd_data_i | csr_src_i;
      csr_pkg::op_rc: new_val = rd_data_i & ~csr_src_i;
      default:        new_val = rd_data_i;
    endcase
  end

  // field masks are left to the register file.
  assign wr_en_o   = csr_req_i & addr_ok;
  assign wr_addr_o = csr_addr_i;
  assign wr_data_o = new_val;

endmodule

// File: csr_pkg.sv
package csr_pkg;

  // ####################
  // widths
  // ####################

  localparam int unsigned xlen       = 64;
  localparam int unsigned csr_addr_w = 12;

  // ####################
  // CSR addresses
  // ####################

  localparam logic [csr_addr_w-1:0] csr_mstatus = 12'h300;
  localparam logic [csr_addr_w-1:0] csr_mtvec   = 12'h305;
  localparam logic [csr_addr_w-1:0] csr_mepc    = 12'h341;
  localparam logic [csr_addr_w-1:0] csr_mcause  = 12'h342;
  localparam logic [csr_addr_w-1:0] csr_mtval   = 12'h343;

  // ####################
  // CSR operations
  // ####################

  // encoded like the low two bits of funct3 for CSRRW, CSRRS and CSRRC.
  typedef enum logic [1:0] {
    op_rw = 2'b01,
    op_rs = 2'b10,
    op_rc = 2'b11
  } csr_op_t;

  // ####################
  // field layout
  // ####################

  localparam int unsigned mstatus_mie_bit  = 3;
  localparam int unsigned mstatus_mpie_bit = 7;
  localparam int unsigned mstatus_mpp_lsb  = 11;

  // only M-mode exists, so MPP is hardwired to 3.
  localparam logic [1:0] mstatus_mpp_val = 2'b11;

  // only MIE and MPIE are writable.
  localparam logic [xlen-1:0] mstatus_wmask =
      (64'd1 << mstatus_mie_bit) | (64'd1 << mstatus_mpie_bit);

  // direct mode only, base is 4-byte aligned.
  localparam logic [xlen-1:0] mtvec_wmask = ~64'd3;

  // no compressed instructions, so mepc is 4-byte aligned too.
  localparam logic [xlen-1:0] mepc_wmask = ~64'd3;

endpackage

// File: csr_regfile.sv
module csr_regfile (
  input  logic                            clk,
  input  logic                            arst_n_i,
  input  logic [csr_pkg::csr_addr_w-1:0]  rd_addr_i,
  input  logic                            wr_en_i,
  input  logic [csr_pkg::csr_addr_w-1:0]  wr_addr_i,
  input  logic [csr_pkg::xlen-1:0]        wr_data_i,
  input  logic                            mstatus_we_i,
  input  logic [csr_pkg::xlen-1:0]        mstatus_d_i,
  input  logic                            mepc_we_i,
  input  logic [csr_pkg::xlen-1:0]        mepc_d_i,
  input  logic                            mcause_we_i,
  input  logic [csr_pkg::xlen-1:0]        mcause_d_i,
  input  logic                            mtval_we_i,
  input  logic [csr_pkg::xlen-1:0]        mtval_d_i,
  output logic [csr_pkg::xlen-1:0]        rd_data_o,
  output logic [csr_pkg::xlen-1:0]        mstatus_o,
  output logic [csr_pkg::xlen-1:0]        mepc_o,
  output logic [csr_pkg::xlen-1:0]        mtvec_o
);

  logic [csr_pkg::xlen-1:0] mstatus_q;
  logic [csr_pkg::xlen-1:0] mtvec_q;
  logic [csr_pkg::xlen-1:0] mepc_q;
  logic [csr_pkg::xlen-1:0] mcause_q;
  logic [csr_pkg::xlen-1:0] mtval_q;

  logic hit_mstatus;
  logic hit_mtvec;
  logic hit_mepc;
  logic hit_mcause;
  logic hit_mtval;

  logic [csr_pkg::xlen-1:0] mstatus_nxt;
  logic [csr_pkg::xlen-1:0] mepc_nxt;
  logic [csr_pkg::xlen-1:0] mcause_nxt;
  logic [csr_pkg::xlen-1:0] mtval_nxt;
  logic [csr_pkg::xlen-1:0] mstatus_view;

  // ####################
  // write select
  // ####################

  always_comb begin
    hit_mstatus = 1'b0;
    hit_mtvec   = 1'b0;
    hit_mepc    = 1'b0;
    hit_mcause  = 1'b0;
    hit_mtval   = 1'b0;
    if (wr_en_i) begin
      case (wr_addr_i)
        csr_pkg::csr_mstatus: hit_mstatus = 1'b1;
        csr_pkg::csr_mtvec:   hit_mtvec   = 1'b1;
        csr_pkg::csr_mepc:    hit_mepc    = 1'b1;
        csr_pkg::csr_mcause:  hit_mcause  = 1'b1;
        csr_pkg::csr_mtval:   hit_mtval   = 1'b1;
        default: ;
      endcase
    end
  end

  // the trap side wins over an addressed write to the same register.
  assign mstatus_nxt = mstatus_we_i ? mstatus_d_i : wr_data_i;
  assign mepc_nxt    = mepc_we_i    ? mepc_d_i    : wr_data_i;
  assign mcause_nxt  = mcause_we_i  ? mcause_d_i  : wr_data_i;
  assign mtval_nxt   = mtval_we_i   ? mtval_d_i   : wr_data_i;

  // ####################
  // registers
  // ####################

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
      mtval_q   <= '0;
    end else begin
      if (mstatus_we_i || hit_mstatus) begin
        mstatus_q <= mstatus_nxt & csr_pkg::mstatus_wmask;
      end
      if (hit_mtvec) begin
        mtvec_q <= wr_data_i & csr_pkg::mtvec_wmask;
      end
      if (mepc_we_i || hit_mepc) begin
        mepc_q <= mepc_nxt & csr_pkg::mepc_wmask;
      end
      if (mcause_we_i || hit_mcause) begin
        mcause_q <= mcause_nxt;
      end
      if (mtval_we_i || hit_mtval) begin
        mtval_q <= mtval_nxt;
      end
    end
  end

  // ####################
  // read side
  // ####################

  always_comb begin
    mstatus_view = mstatus_q;
    mstatus_view[csr_pkg::mstatus_mpp_lsb +: 2] = csr_pkg::mstatus_mpp_val;
  end

  always_comb begin
    case (rd_addr_i)
      csr_pkg::csr_mstatus: rd_data_o = mstatus_view;
      csr_pkg::csr_mtvec:   rd_data_o = mtvec_q;
      csr_pkg::csr_mepc:    rd_data_o = mepc_q;
      csr_pkg::csr_mcause:  rd_data_o = mcause_q;
      csr_pkg::csr_mtval:   rd_data_o = mtval_q;
      default:              rd_data_o = '0;
    endcase
  end

  assign mstatus_o = mstatus_view;
  assign mepc_o    = mepc_q;
  assign mtvec_o   = mtvec_q;

endmodule

// File: csr_trap_top.sv
module csr_trap_top (
  input  logic                            clk,
  input  logic                            arst_n_i,
  input  logic                            csr_req_i,
  input  logic [csr_pkg::csr_addr_w-1:0]  csr_addr_i,
  input  csr_pkg::csr_op_t                csr_op_i,
  input  logic [csr_pkg::xlen-1:0]        csr_src_i,
  input  logic                            trap_i,
  input  logic [csr_pkg::xlen-1:0]        trap_cause_i,
  input  logic [csr_pkg::xlen-1:0]        trap_epc_i,
  input  logic [csr_pkg::xlen-1:0]        trap_tval_i,
  input  logic                            mret_i,
  output logic [csr_pkg::xlen-1:0]        csr_rdata_o,
  output logic                            csr_illegal_o,
  output logic                            redirect_o,
  output logic [csr_pkg::xlen-1:0]        redirect_pc_o
);

  logic [csr_pkg::csr_addr_w-1:0] rd_addr;
  logic [csr_pkg::xlen-1:0]       rd_data;
  logic                           wr_en;
  logic [csr_pkg::csr_addr_w-1:0] wr_addr;
  logic [csr_pkg::xlen-1:0]       wr_data;

  logic [csr_pkg::xlen-1:0] mstatus_q;
  logic [csr_pkg::xlen-1:0] mepc_q;
  logic [csr_pkg::xlen-1:0] mtvec_q;

  logic                     mstatus_we;
  logic [csr_pkg::xlen-1:0] mstatus_d;
  logic                     mepc_we;
  logic [csr_pkg::xlen-1:0] mepc_d;
  logic                     mcause_we;
  logic [csr_pkg::xlen-1:0] mcause_d;
  logic                     mtval_we;
  logic [csr_pkg::xlen-1:0] mtval_d;

  csr_access_unit u_csr_access_unit (
    .csr_req_i     (csr_req_i),
    .csr_addr_i    (csr_addr_i),
    .csr_op_i      (csr_op_i),
    .csr_src_i     (csr_src_i),
    .rd_data_i     (rd_data),
    .rd_addr_o     (rd_addr),
    .csr_rdata_o   (csr_rdata_o),
    .csr_illegal_o (csr_illegal_o),
    .wr_en_o       (wr_en),
    .wr_addr_o     (wr_addr),
    .wr_data_o     (wr_data)
  );

  csr_trap_unit u_csr_trap_unit (
    .trap_i        (trap_i),
    .trap_cause_i  (trap_cause_i),
    .trap_epc_i    (trap_epc_i),
    .trap_tval_i   (trap_tval_i),
    .mret_i        (mret_i),
    .mstatus_i     (mstatus_q),
    .mepc_i        (mepc_q),
    .mtvec_i       (mtvec_q),
    .mstatus_we_o  (mstatus_we),
    .mstatus_d_o   (mstatus_d),
    .mepc_we_o     (mepc_we),
    .mepc_d_o      (mepc_d),
    .mcause_we_o   (mcause_we),
    .mcause_d_o    (mcause_d),
    .mtval_we_o    (mtval_we),
    .mtval_d_o     (mtval_d),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o)
  );

  csr_regfile u_csr_regfile (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .rd_addr_i    (rd_addr),
    .wr_en_i      (wr_en),
    .wr_addr_i    (wr_addr),
    .wr_data_i    (wr_data),
    .mstatus_we_i (mstatus_we),
    .mstatus_d_i  (mstatus_d),
    .mepc_we_i    (mepc_we),
    .mepc_d_i     (mepc_d),
    .mcause_we_i  (mcause_we),
    .mcause_d_i   (mcause_d),
    .mtval_we_i   (mtval_we),
    .mtval_d_i    (mtval_d),
    .rd_data_o    (rd_data),
    .mstatus_o    (mstatus_q),
    .mepc_o       (mepc_q),
    .mtvec_o      (mtvec_q)
  );

endmodule

// File: csr_trap_unit.sv
module csr_trap_unit (
  input  logic                     trap_i,
  input  logic [csr_pkg::xlen-1:0] trap_cause_i,
  input  logic [csr_pkg::xlen-1:0] trap_epc_i,
  input  logic [csr_pkg::xlen-1:0] trap_tval_i,
  input  logic                     mret_i,
  input  logic [csr_pkg::xlen-1:0] mstatus_i,
  input  logic [csr_pkg::xlen-1:0] mepc_i,
  input  logic [csr_pkg::xlen-1:0] mtvec_i,
  output logic                     mstatus_we_o,
  output logic [csr_pkg::xlen-1:0] mstatus_d_o,
  output logic                     mepc_we_o,
  output logic [csr_pkg::xlen-1:0] mepc_d_o,
  output logic                     mcause_we_o,
  output logic [csr_pkg::xlen-1:0] mcause_d_o,
  output logic                     mtval_we_o,
  output logic [csr_pkg::xlen-1:0] mtval_d_o,
  output logic                     redirect_o,
  output logic [csr_pkg::xlen-1:0] redirect_pc_o
);

  logic old_mie;
  logic old_mpie;

  assign old_mie  = mstatus_i[csr_pkg::mstatus_mie_bit];
  assign old_mpie = mstatus_i[csr_pkg::mstatus_mpie_bit];

  // ####################
  // trap entry and mret
  // ####################

  always_comb begin
    mstatus_we_o  = 1'b0;
    mstatus_d_o   = mstatus_i;
    mepc_we_o     = 1'b0;
    mepc_d_o      = trap_epc_i;
    mcause_we_o   = 1'b0;
    mcause_d_o    = trap_cause_i;
    mtval_we_o    = 1'b0;
    mtval_d_o     = trap_tval_i;
    redirect_o    = 1'b0;
    redirect_pc_o = '0;

    if (trap_i) begin
      // the interrupt enable is stacked and cleared on entry.
      mstatus_we_o = 1'b1;
      mstatus_d_o[csr_pkg::mstatus_mpie_bit] = old_mie;
      mstatus_d_o[csr_pkg::mstatus_mie_bit]  = 1'b0;
      mepc_we_o     = 1'b1;
      mcause_we_o   = 1'b1;
      mtval_we_o    = 1'b1;
      redirect_o    = 1'b1;
      redirect_pc_o = mtvec_i;
    end else if (mret_i) begin
      // unstack the interrupt enable, MPIE goes back to one.
      mstatus_we_o = 1'b1;
      mstatus_d_o[csr_pkg::mstatus_mie_bit]  = old_mpie;
      mstatus_d_o[csr_pkg::mstatus_mpie_bit] = 1'b1;
      redirect_o    = 1'b1;
      redirect_pc_o = mepc_i;
    end
  end

endmodule

// File: src.f
csr_pkg.sv
csr_access_unit.sv
csr_trap_unit.sv
csr_regfile.sv
csr_trap_top.sv
tb_csr_trap_top.sv

// File: tb_csr_trap_top.sv
module tb_csr_trap_top;

  logic        clk;
  logic        arst_n_i;
  logic        csr_req_i;
  logic [11:0] csr_addr_i;
  csr_pkg::csr_op_t csr_op_i;
  logic [63:0] csr_src_i;
  logic        trap_i;
  logic [63:0] trap_cause_i;
  logic [63:0] trap_epc_i;
  logic [63:0] trap_tval_i;
  logic        mret_i;
  logic [63:0] csr_rdata_o;
  logic        csr_illegal_o;
  logic        redirect_o;
  logic [63:0] redirect_pc_o;

  logic [15:0] lfsr;
  logic [63:0] m_mstatus;
  logic [63:0] m_mtvec;
  logic [63:0] m_mepc;
  logic [63:0] m_mcause;
  logic [63:0] m_mtval;

  csr_trap_top u_csr_trap_top (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ####################
  // helpers
  // ####################

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand64(output logic [63:0] v);
    for (int i = 0; i < 64; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string test, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", test, exp, act);
      $display("Result: FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic wait_redirect(input string test);
    int n;
    n = 0;
    do begin
      #1;
      n++;
    end while (!redirect_o && n < 1);
    if (!redirect_o) begin
      $display("%s: redirect never went high in the strobe cycle", test);
      $display("Result: FAILED");
      $fatal(1, "redirect timeout");
    end
  endtask

  // MPP always reads as 3 in the model, and unknown addresses read zero.
  function automatic logic [63:0] model_read(input logic [11:0] addr);
    case (addr)
      csr_pkg::csr_mstatus: return m_mstatus | 64'h1800;
      csr_pkg::csr_mtvec:   return m_mtvec;
      csr_pkg::csr_mepc:    return m_mepc;
      csr_pkg::csr_mcause:  return m_mcause;
      csr_pkg::csr_mtval:   return m_mtval;
      default:              return 64'd0;
    endcase
  endfunction

  // only MIE and MPIE are writable, mtvec and mepc drop their two low bits.
  function automatic void model_write(input logic [11:0] addr, input logic [63:0] val);
    case (addr)
      csr_pkg::csr_mstatus: m_mstatus = val & 64'h88;
      csr_pkg::csr_mtvec:   m_mtvec = val & ~64'h3;
      csr_pkg::csr_mepc:    m_mepc = val & ~64'h3;
      csr_pkg::csr_mcause:  m_mcause = val;
      csr_pkg::csr_mtval:   m_mtval = val;
      default: ;
    endcase
  endfunction

  function automatic void model_trap(input logic [63:0] cause, input logic [63:0] epc,
                                     input logic [63:0] tval);
    m_mstatus = {56'd0, m_mstatus[3], 7'd0};
    m_mepc = epc & ~64'h3;
    m_mcause = cause;
    m_mtval = tval;
  endfunction

  task automatic csr_access(input string test, input csr_pkg::csr_op_t op,
                            input logic [11:0] addr, input logic [63:0] src);
    logic [63:0] old_val;
    logic [63:0] new_val;
    old_val = model_read(addr);
    case (op)
      csr_pkg::op_rw: new_val = src;
      csr_pkg::op_rs: new_val = old_val | src;
      default:        new_val = old_val & ~src;
    endcase
    @(negedge clk);
    csr_req_i = 1'b1;
    csr_addr_i = addr;
    csr_op_i = op;
    csr_src_i = src;
    #1;
    check_value({test, " rdata"}, old_val, csr_rdata_o);
    check_value({test, " illegal"}, 64'd0, {63'd0, csr_illegal_o});
    @(negedge clk);
    csr_req_i = 1'b0;
    model_write(addr, new_val);
  endtask

  task automatic check_all(input string test);
    csr_access({test, " mstatus"}, csr_pkg::op_rs, csr_pkg::csr_mstatus, 64'd0);
    csr_access({test, " mtvec"}, csr_pkg::op_rs, csr_pkg::csr_mtvec, 64'd0);
    csr_access({test, " mepc"}, csr_pkg::op_rs, csr_pkg::csr_mepc, 64'd0);
    csr_access({test, " mcause"}, csr_pkg::op_rs, csr_pkg::csr_mcause, 64'd0);
    csr_access({test, " mtval"}, csr_pkg::op_rs, csr_pkg::csr_mtval, 64'd0);
  endtask

  task automatic strobe_trap(input string test, input logic [63:0] cause,
                             input logic [63:0] epc, input logic [63:0] tval);
    trap_i = 1'b1;
    trap_cause_i = cause;
    trap_epc_i = epc;
    trap_tval_i = tval;
    wait_redirect(test);
    check_value({test, " pc"}, m_mtvec, redirect_pc_o);
  endtask

  task automatic strobe_mret(input string test);
    @(negedge clk);
    mret_i = 1'b1;
    wait_redirect(test);
    check_value({test, " pc"}, m_mepc, redirect_pc_o);
    @(negedge clk);
    mret_i = 1'b0;
    m_mstatus = {56'd0, 1'b1, 3'd0, m_mstatus[7], 3'd0};
    check_all(test);
  endtask

  // ####################
  // tests
  // ####################

  task automatic reset_values();
    check_value("reset redirect", 64'd0, {63'd0, redirect_o});
    check_all("reset");
  endtask

  task automatic csr_operations();
    logic [11:0] addrs [5];
    logic [63:0] v;
    addrs = '{csr_pkg::csr_mstatus, csr_pkg::csr_mtvec, csr_pkg::csr_mepc,
              csr_pkg::csr_mcause, csr_pkg::csr_mtval};
    foreach (addrs[i]) begin
      rand64(v);
      csr_access("csrrw", csr_pkg::op_rw, addrs[i], v);
      check_all("csrrw readback");
      rand64(v);
      csr_access("csrrs", csr_pkg::op_rs, addrs[i], v);
      check_all("csrrs readback");
      rand64(v);
      csr_access("csrrc", csr_pkg::op_rc, addrs[i], v);
      check_all("csrrc readback");
    end
  endtask

  task automatic illegal_address();
    logic [63:0] v;
    rand64(v);
    @(negedge clk);
    csr_req_i = 1'b1;
    csr_addr_i = 12'h7C0;
    csr_op_i = csr_pkg::op_rw;
    csr_src_i = v;
    #1;
    check_value("illegal flag", 64'd1, {63'd0, csr_illegal_o});
    check_value("illegal rdata", 64'd0, csr_rdata_o);
    @(negedge clk);
    csr_req_i = 1'b0;
    check_all("illegal");
  endtask

  task automatic trap_entry();
    logic [63:0] v;
    logic [63:0] cause;
    logic [63:0] epc;
    logic [63:0] tval;
    csr_access("trap set mie", csr_pkg::op_rs, csr_pkg::csr_mstatus, 64'h8);
    rand64(v);
    csr_access("trap mtvec", csr_pkg::op_rw, csr_pkg::csr_mtvec, v);
    rand64(cause);
    rand64(epc);
    rand64(tval);
    @(negedge clk);
    strobe_trap("trap entry", cause, epc, tval);
    @(negedge clk);
    trap_i = 1'b0;
    model_trap(cause, epc, tval);
    check_all("trap entry");
  endtask

  task automatic mret_return();
    // MPIE is one after the trap, then both enables are cleared for a second pass.
    strobe_mret("mret mpie set");
    csr_access("mret clear", csr_pkg::op_rc, csr_pkg::csr_mstatus, 64'h88);
    strobe_mret("mret mpie clear");
  endtask

  task automatic trap_priority();
    logic [63:0] src;
    logic [63:0] cause;
    logic [63:0] epc;
    logic [63:0] tval;
    rand64(src);
    rand64(cause);
    rand64(epc);
    rand64(tval);
    @(negedge clk);
    csr_req_i = 1'b1;
    csr_addr_i = csr_pkg::csr_mcause;
    csr_op_i = csr_pkg::op_rw;
    csr_src_i = src;
    strobe_trap("priority", cause, epc, tval);
    check_value("priority rdata", m_mcause, csr_rdata_o);
    @(negedge clk);
    csr_req_i = 1'b0;
    trap_i = 1'b0;
    model_trap(cause, epc, tval);
    check_all("priority");
  endtask

  initial begin
    lfsr = 16'd57247;
    arst_n_i = 1'b0;
    csr_req_i = 1'b0;
    csr_addr_i = '0;
    csr_op_i = csr_pkg::op_rw;
    csr_src_i = '0;
    trap_i = 1'b0;
    trap_cause_i = '0;
    trap_epc_i = '0;
    trap_tval_i = '0;
    mret_i = 1'b0;
    m_mstatus = '0;
    m_mtvec = '0;
    m_mepc = '0;
    m_mcause = '0;
    m_mtval = '0;
    repeat (4) @(negedge clk);
    arst_n_i = 1'b1;
    reset_values();
    csr_operations();
    illegal_address();
    trap_entry();
    mret_return();
    trap_priority();
    $display("Result: PASSED");
    $finish;
  end

endmodule
